// File: bench/stress_tb_model.svh
`ifndef STRESS_TB_MODEL_SVH
`define STRESS_TB_MODEL_SVH

// Expected pins after each run clock
logic exp_tck [$];
logic exp_tms [$];
logic exp_tdi [$];

// Unknown codes run as sustained
function automatic logic [7:0] mode_of_code(input logic [7:0] code);
    if (code == 8'd1 || code == 8'd2 || code == 8'd3 || code == 8'd8) begin
        return code;
    end
    return 8'd6;
endfunction

function automatic int divider_of(input logic [7:0] code);
    case (mode_of_code(code))
        8'd1:    return 1;
        8'd2:    return 2;
        8'd3:    return `STRESS_MIN_DIVIDER;
        default: return 4;
    endcase
endfunction

function automatic logic [7:0] level_of(input logic [7:0] code);
    case (mode_of_code(code))
        8'd1:    return 8'hff;
        8'd2:    return 8'hc0;
        8'd3:    return 8'h10;
        default: return 8'h80;
    endcase
endfunction

// Only power cycle mode has off phases, every second power period
function automatic bit phase_is_on(input logic [7:0] code, input int r);
    return mode_of_code(code) != 8'd8 || ((r / `STRESS_POWER_PERIOD) % 2) == 0;
endfunction

function automatic int expected_toggles(input logic [7:0] code);
    int count;
    int r;
    count = 0;
    for (r = 0; r < `STRESS_DURATION_CYCLES; r++) begin
        if (phase_is_on(code, r) && (r % divider_of(code)) == 0) begin
            count++;
        end
    end
    return count;
endfunction

function automatic void build_pin_trace(input logic [7:0] code);
    logic [7:0]  mode;
    logic [7:0]  pat;
    logic [31:0] lfsr;
    logic [2:0]  idx;
    logic        tck;
    logic        tms;
    logic        tdi;
    int          r;
    mode = mode_of_code(code);
    lfsr = `STRESS_LFSR_SEED;
    tck = 1'b0;
    tms = 1'b0;
    tdi = 1'b0;
    exp_tck.delete();
    exp_tms.delete();
    exp_tdi.delete();
    for (r = 0; r < `STRESS_DURATION_CYCLES; r++) begin
        idx = 3'(r);
        if (!phase_is_on(code, r)) begin
            tck = 1'b0;
            tms = 1'b0;
            tdi = 1'b0;
        end else if ((r % divider_of(code)) == 0) begin
            tck = !tck;
            case (mode)
                8'd1: begin
                    pat = 8'h55;
                    tms = pat[idx];
                    tdi = lfsr[0];
                    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                end
                8'd2: begin
                    // New TMS pattern every 64 run clocks
                    pat = (r % 256 < 64) ? 8'h55 : (r % 256 < 128) ? 8'haa :
                          (r % 256 < 192) ? 8'hff : 8'h00;
                    tms = pat[idx];
                    tdi = !tdi;
                end
                8'd3: begin
                    tms = 1'b0;
                    tdi = 1'b0;
                end
                8'd8: begin
                    tms = r[2];
                    tdi = r[3];
                end
                default: begin
                    tms = r[3];
                    tdi = r[4];
                end
            endcase
        end
        exp_tck.push_back(tck);
        exp_tms.push_back(tms);
        exp_tdi.push_back(tdi);
    end
endfunction

`endif

// File: bench/stress_tb.sv
`default_nettype none

`include "stress_cfg.svh"

module stress_tb
    import stress_pkg::*;
();

    localparam int DURATION = `STRESS_DURATION_CYCLES;
    localparam int RUN_TIMEOUT = DURATION + 10;
    localparam int NUM_RUNS = 16;
    localparam int WATCHDOG_TIME = 20 * NUM_RUNS * (DURATION + 10) * 10;

    logic         clk;
    logic         reset;
    logic         enable;
    logic [7:0]   stress_mode;
    logic         stress_tck;
    logic         stress_tms;
    logic         stress_tdi;
    logic         stress_complete;
    logic         boundary_violation;
    cycle_count_t toggle_count;
    cycle_count_t error_count;
    cycle_count_t cycles_completed;
    freq_t        max_frequency_achieved;
    freq_t        current_frequency;
    level_t       stress_level;

    // Pins seen at each falling edge of the last run
    logic seen_tck [$];
    logic seen_tms [$];
    logic seen_tdi [$];

    `include "stress_tb_model.svh"

    stress_tester dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Generous bound on all runs together
    initial begin
        #(WATCHDOG_TIME);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired before the tests finished");
    end

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s expected %h got %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("TEST FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic run_mode(input logic [7:0] code);
        int waited;
        seen_tck.delete();
        seen_tms.delete();
        seen_tdi.delete();
        waited = 0;
        @(negedge clk);
        stress_mode = code;
        enable = 1'b1;
        do begin
            @(negedge clk);
            seen_tck.push_back(stress_tck);
            seen_tms.push_back(stress_tms);
            seen_tdi.push_back(stress_tdi);
            waited++;
            expect_true(stress_complete || waited < RUN_TIMEOUT,
                        "stress_complete did not rise before the run timeout");
        end while (!stress_complete);
        // Last TCK edge reaches the toggle counters one clock later
        repeat (2) @(negedge clk);
        expect_true(waited == DURATION + 2,
                    $sformatf("run took %0d clocks from enable to completion", waited));
    endtask

    task automatic end_run();
        enable = 1'b0;
        @(negedge clk);
        expect_equal("stress_complete", 32'd0, 32'(stress_complete));
    endtask

    // Samples 0 and 1 are INIT and the first run clock, before any step lands
    task automatic compare_pin_trace(input logic [7:0] code);
        int r;
        build_pin_trace(code);
        for (r = 0; r < DURATION; r++) begin
            expect_equal($sformatf("stress_tck at run clock %0d", r),
                         32'(exp_tck[r]), 32'(seen_tck[r + 2]));
            expect_equal($sformatf("stress_tms at run clock %0d", r),
                         32'(exp_tms[r]), 32'(seen_tms[r + 2]));
            expect_equal($sformatf("stress_tdi at run clock %0d", r),
                         32'(exp_tdi[r]), 32'(seen_tdi[r + 2]));
        end
    endtask

    task automatic reset_and_completion();
        expect_equal("{stress_tck,stress_tms,stress_tdi}", 32'd0,
                     32'({stress_tck, stress_tms, stress_tdi}));
        expect_equal("stress_complete", 32'd0, 32'(stress_complete));
        expect_equal("boundary_violation", 32'd0, 32'(boundary_violation));
        expect_equal("toggle_count", 32'd0, toggle_count);
        expect_equal("error_count", 32'd0, error_count);
        expect_equal("cycles_completed", 32'd0, cycles_completed);
        expect_equal("current_frequency", 32'd0, 32'(current_frequency));
        expect_equal("max_frequency_achieved", 32'd0, 32'(max_frequency_achieved));
        run_mode(8'd6);
        expect_equal("stress_complete", 32'd1, 32'(stress_complete));
        expect_equal("cycles_completed", DURATION, cycles_completed);
        end_run();
    endtask

    // Runs code and expects the counts, rate and level of like_code
    task automatic toggles_and_frequency(input logic [7:0] code, input logic [7:0] like_code);
        int div;
        div = divider_of(like_code);
        run_mode(code);
        expect_equal("toggle_count", (DURATION + div - 1) / div, toggle_count);
        expect_equal("current_frequency", `STRESS_CLOCK_FREQ_MHZ / div, 32'(current_frequency));
        expect_equal("stress_level", 32'(level_of(like_code)), 32'(stress_level));
        end_run();
    endtask

    task automatic violation_rule();
        run_mode(8'd1);
        expect_equal("boundary_violation", 32'd1, 32'(boundary_violation));
        expect_equal("toggle_count", expected_toggles(8'd1), toggle_count);
        expect_equal("error_count", expected_toggles(8'd1), error_count);
        expect_equal("max_frequency_achieved", 100, 32'(max_frequency_achieved));
        end_run();
        run_mode(8'd2);
        expect_equal("boundary_violation", 32'd0, 32'(boundary_violation));
        expect_equal("error_count", 32'd0, error_count);
        expect_equal("max_frequency_achieved", 100, 32'(max_frequency_achieved));
        end_run();
        run_mode(8'd6);
        expect_equal("max_frequency_achieved", 100, 32'(max_frequency_achieved));
        end_run();
    endtask

    task automatic pin_sequence(input logic [7:0] code);
        run_mode(code);
        compare_pin_trace(code);
        end_run();
    endtask

    task automatic power_cycle_run();
        int r;
        run_mode(8'd8);
        for (r = 0; r < DURATION; r++) begin
            if (!phase_is_on(8'd8, r)) begin
                expect_true({seen_tck[r + 2], seen_tms[r + 2], seen_tdi[r + 2]} == 3'b000,
                            $sformatf("pins not low in power off phase at run clock %0d", r));
            end
        end
        compare_pin_trace(8'd8);
        expect_equal("toggle_count", expected_toggles(8'd8), toggle_count);
        end_run();
    endtask

    task automatic unknown_codes();
        logic [7:0] code;
        int         n;
        for (n = 0; n < 4; n++) begin
            do begin
                code = 8'($urandom);
            end while (code inside {8'd1, 8'd2, 8'd3, 8'd6, 8'd8});
            toggles_and_frequency(code, 8'd6);
        end
    endtask

    initial begin
        void'($urandom(32'h7c8e));
        enable = 1'b0;
        stress_mode = 8'd0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_and_completion();
        toggles_and_frequency(8'd1, 8'd1);
        toggles_and_frequency(8'd2, 8'd2);
        toggles_and_frequency(8'd3, 8'd3);
        toggles_and_frequency(8'd6, 8'd6);
        violation_rule();
        pin_sequence(8'd1);
        pin_sequence(8'd2);
        pin_sequence(8'd6);
        power_cycle_run();
        unknown_codes();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
+incdir+bench
verilog/stress_pkg.sv
verilog/stress_sequencer.sv
verilog/jtag_pattern_gen.sv
verilog/activity_monitor.sv
verilog/stress_tester.sv
bench/stress_tb.sv

// File: run.sh
#!/bin/sh
# Builds the stress tester testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module stress_tb -o stress_tb_sim &&
./obj_dir/stress_tb_sim || exit 1

// File: verilog/activity_monitor.sv
`default_nettype none

`include "stress_cfg.svh"

module activity_monitor
    import stress_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic         tck,
    input  divider_t     divider,
    output logic         boundary_violation,
    output cycle_count_t toggle_count,
    output cycle_count_t error_count,
    output freq_t        current_frequency,
    output freq_t        max_frequency_achieved
);

    logic  tck_d;
    logic  start_d;
    logic  tck_change;
    freq_t freq_new;

    assign tck_change = tck ^ tck_d;

    // TCK rate for the divider of the current run
    assign freq_new = freq_t'(`STRESS_CLOCK_FREQ_MHZ / 32'(divider));

    // Toggle and error counting
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tck_d              <= 1'b0;
            toggle_count       <= '0;
            error_count        <= '0;
            boundary_violation <= 1'b0;
        end else if (start) begin
            // Generator drives TCK low on start, so no edge is seen next clock
            tck_d              <= 1'b0;
            toggle_count       <= '0;
            error_count        <= '0;
            boundary_violation <= 1'b0;
        end else begin
            tck_d <= tck;
            if (tck_change) begin
                toggle_count <= toggle_count + 32'd1;
                if (current_frequency > freq_t'(`STRESS_MAX_TOGGLE_RATE)) begin
                    error_count        <= error_count + 32'd1;
                    boundary_violation <= 1'b1;
                end
            end
        end
    end

    // Frequency tracking
    // Divider is latched in the start clock, so sample it one clock later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_d                <= 1'b0;
            current_frequency      <= '0;
            max_frequency_achieved <= '0;
        end else begin
            start_d <= start;
            if (start_d) begin
                current_frequency <= freq_new;
                // Peak survives across runs
                if (freq_new > max_frequency_achieved) begin
                    max_frequency_achieved <= freq_new;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/jtag_pattern_gen.sv
`default_nettype none

`include "stress_cfg.svh"

module jtag_pattern_gen
    import stress_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic         run,
    input  stress_mode_t mode,
    input  divider_t     divider,
    input  cycle_count_t run_count,
    output logic         tck,
    output logic         tms,
    output logic         tdi
);

    divider_t     step_cnt;
    cycle_count_t pwr_cnt;
    lfsr_t        lfsr;
    logic         power_on;
    logic         power_now;
    logic         power_flip;
    logic         step;
    logic [7:0]   rapid_pat;

    // Step when run_count is a multiple of the divider
    assign step = run && (step_cnt == '0);

    // Phase flips on every nonzero multiple of the power period
    assign power_flip = run && (run_count != '0) && (pwr_cnt == '0);

    // Flipped phase already applies in the clock of the flip
    assign power_now = power_flip ? ~power_on : power_on;

    // Rapid toggle walks through four TMS patterns
    always_comb begin
        case (run_count[7:6])
            2'd0:    rapid_pat = 8'h55;
            2'd1:    rapid_pat = 8'haa;
            2'd2:    rapid_pat = 8'hff;
            default: rapid_pat = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step_cnt <= '0;
            pwr_cnt  <= '0;
        end else if (start) begin
            step_cnt <= '0;
            pwr_cnt  <= '0;
        end else if (run) begin
            if (step_cnt == divider - 16'd1) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 16'd1;
            end
            if (pwr_cnt == cycle_count_t'(`STRESS_POWER_PERIOD - 1)) begin
                pwr_cnt <= '0;
            end else begin
                pwr_cnt <= pwr_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tck      <= 1'b0;
            tms      <= 1'b0;
            tdi      <= 1'b0;
            lfsr     <= `STRESS_LFSR_SEED;
            power_on <= 1'b1;
        end else if (start) begin
            tck      <= 1'b0;
            tms      <= 1'b0;
            tdi      <= 1'b0;
            lfsr     <= `STRESS_LFSR_SEED;
            power_on <= 1'b1;
        end else if (run) begin
            power_on <= power_now;
            if (mode == MODE_POWER_CYCLE && !power_now) begin
                // Powered down, all pins held low
                tck <= 1'b0;
                tms <= 1'b0;
                tdi <= 1'b0;
            end else if (step) begin
                tck <= ~tck;
                case (mode)
                    MODE_HIGH_FREQ: begin
                        tms  <= rapid_pat_55(run_count[2:0]);
                        tdi  <= lfsr[0];
                        lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                    end
                    MODE_RAPID_TOGGLE: begin
                        tms <= rapid_pat[run_count[2:0]];
                        tdi <= ~tdi;
                    end
                    MODE_BOUNDARY_MIN: begin
                        tms <= 1'b0;
                        tdi <= 1'b0;
                    end
                    MODE_POWER_CYCLE: begin
                        tms <= run_count[2];
                        tdi <= run_count[3];
                    end
                    // Sustained
                    default: begin
                        tms <= run_count[3];
                        tdi <= run_count[4];
                    end
                endcase
            end
        end
    end

    // Bit of the fixed 55 pattern used by high frequency mode
    function automatic logic rapid_pat_55(input logic [2:0] idx);
        logic [7:0] pat;
        pat = 8'h55;
        return pat[idx];
    endfunction

endmodule

`default_nettype wire

// File: verilog/stress_cfg.svh
`ifndef STRESS_CFG_SVH
`define STRESS_CFG_SVH

// System clock rate in MHz
`define STRESS_CLOCK_FREQ_MHZ 100

// Clocks spent in the run phase of one stress run
`define STRESS_DURATION_CYCLES 200

// TCK frequency limit in MHz
`define STRESS_MAX_TOGGLE_RATE 50

// Slowest TCK, used by boundary minimum mode
`define STRESS_MIN_DIVIDER 16

// Clocks per power phase in power cycle mode
`define STRESS_POWER_PERIOD 40

// TDI scrambler start value
`define STRESS_LFSR_SEED 32'h12345678

`endif

// File: verilog/stress_pkg.sv
`default_nettype none

package stress_pkg;

    // Cycle and toggle counters
    typedef logic [31:0] cycle_count_t;

    // Frequency in MHz
    typedef logic [15:0] freq_t;

    // System clocks per TCK step
    typedef logic [15:0] divider_t;

    typedef logic [7:0] level_t;
    typedef logic [31:0] lfsr_t;

    // Stress mode codes as seen on the stress_mode input
    typedef enum logic [7:0] {
        MODE_HIGH_FREQ    = 8'd1,
        MODE_RAPID_TOGGLE = 8'd2,
        MODE_BOUNDARY_MIN = 8'd3,
        MODE_SUSTAINED    = 8'd6,
        MODE_POWER_CYCLE  = 8'd8
    } stress_mode_t;

    // Run sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INIT,
        ST_RUN,
        ST_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: verilog/stress_sequencer.sv
`default_nettype none

`include "stress_cfg.svh"

module stress_sequencer
    import stress_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  logic [7:0]   stress_mode,
    output logic         run,
    output logic         start,
    output logic         stress_complete,
    output stress_mode_t mode,
    output divider_t     divider,
    output level_t       stress_level,
    output cycle_count_t run_count,
    output cycle_count_t cycles_completed
);

    seq_state_t state;
    seq_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    state_next = ST_INIT;
                end
            end
            ST_INIT: begin
                state_next = ST_RUN;
            end
            ST_RUN: begin
                // Last run clock has count DURATION-1
                if (cycles_completed == cycle_count_t'(`STRESS_DURATION_CYCLES - 1)) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (!enable) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= ST_IDLE;
            cycles_completed <= '0;
        end else begin
            state <= state_next;
            if (state == ST_INIT) begin
                cycles_completed <= '0;
            end else if (state == ST_RUN) begin
                cycles_completed <= cycles_completed + 32'd1;
            end
        end
    end

    // Mode decode, latched once per run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode         <= MODE_SUSTAINED;
            divider      <= 16'd4;
            stress_level <= 8'h00;
        end else if (state == ST_INIT) begin
            case (stress_mode)
                MODE_HIGH_FREQ: begin
                    mode         <= MODE_HIGH_FREQ;
                    divider      <= 16'd1;
                    stress_level <= 8'hff;
                end
                MODE_RAPID_TOGGLE: begin
                    mode         <= MODE_RAPID_TOGGLE;
                    divider      <= 16'd2;
                    stress_level <= 8'hc0;
                end
                MODE_BOUNDARY_MIN: begin
                    mode         <= MODE_BOUNDARY_MIN;
                    divider      <= divider_t'(`STRESS_MIN_DIVIDER);
                    stress_level <= 8'h10;
                end
                MODE_POWER_CYCLE: begin
                    mode         <= MODE_POWER_CYCLE;
                    divider      <= 16'd4;
                    stress_level <= 8'h80;
                end
                // Sustained, and any unknown code
                default: begin
                    mode         <= MODE_SUSTAINED;
                    divider      <= 16'd4;
                    stress_level <= 8'h80;
                end
            endcase
        end
    end

    assign start           = (state == ST_INIT);
    assign run             = (state == ST_RUN);
    assign stress_complete = (state == ST_DONE);

    // Counter equals the run clock index while in RUN
    assign run_count = cycles_completed;

endmodule

`default_nettype wire

// File: verilog/stress_tester.sv
`default_nettype none

module stress_tester
    import stress_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  logic [7:0]   stress_mode,
    output logic         stress_tck,
    output logic         stress_tms,
    output logic         stress_tdi,
    output logic         stress_complete,
    output logic         boundary_violation,
    output cycle_count_t toggle_count,
    output cycle_count_t error_count,
    output cycle_count_t cycles_completed,
    output freq_t        max_frequency_achieved,
    output freq_t        current_frequency,
    output level_t       stress_level
);

    logic         run;
    logic         start;
    stress_mode_t mode;
    divider_t     divider;
    cycle_count_t run_count;

    // Run control and mode decode
    stress_sequencer seq_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .stress_mode      (stress_mode),
        .run              (run),
        .start            (start),
        .stress_complete  (stress_complete),
        .mode             (mode),
        .divider          (divider),
        .stress_level     (stress_level),
        .run_count        (run_count),
        .cycles_completed (cycles_completed)
    );

    // JTAG pin drive
    jtag_pattern_gen gen_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .run       (run),
        .mode      (mode),
        .divider   (divider),
        .run_count (run_count),
        .tck       (stress_tck),
        .tms       (stress_tms),
        .tdi       (stress_tdi)
    );

    // Watches TCK activity against the rate limit
    activity_monitor mon_i (
        .clk                    (clk),
        .reset                  (reset),
        .start                  (start),
        .tck                    (stress_tck),
        .divider                (divider),
        .boundary_violation     (boundary_violation),
        .toggle_count           (toggle_count),
        .error_count            (error_count),
        .current_frequency      (current_frequency),
        .max_frequency_achieved (max_frequency_achieved)
    );

endmodule

`default_nettype wire
